// File: bench/ret_golden.txt
# name fetch_pc exe_valid exe_pc exe_instr exp_valid exp_target (all hex)
# exe_pc on lines with exe_valid 0 is replaced by a random value
b1_call_no_hit 00400100 1 00400000 0c000100 0 00000000
b1_stack_no_hit 00400100 0 00000000 00000000 0 00000000
b2_first_return 00400100 1 00400100 03e00008 0 00000000
b3_empty_stack 00400100 1 00400200 0c000100 0 00000000
b2_outer_call 00400100 1 00400300 0100f809 1 00400208
b2_inner_top 00400100 0 00000000 00000000 1 00400308
b6_pop_same_cycle 00400100 1 00400100 03e00008 1 00400308
b6_below_top 00400100 0 00000000 00000000 1 00400208
b2_outer_pop 00400100 1 00400100 03e00008 1 00400208
b3_call_1 00400100 1 00401000 0c000100 0 00000000
b3_call_2 00400100 1 00401010 0c000100 1 00401008
b3_call_3 00400100 1 00401020 0100f809 1 00401018
b3_call_4 00400100 1 00401030 0c000100 1 00401028
b3_call_5 00400100 1 00401040 0c000100 1 00401038
b3_pop_5 00400100 1 00400100 03e00008 1 00401048
b3_pop_4 00400100 1 00400100 03e00008 1 00401038
b3_pop_3 00400100 1 00400100 03e00008 1 00401028
b3_pop_2 00400100 1 00400100 03e00008 1 00401018
b3_oldest_lost 00400100 0 00000000 00000000 0 00000000
b4_ret_q1 00402008 1 00402008 03e00008 0 00000000
b4_ret_q2 00402008 1 00403008 03e00008 0 00000000
b4_ret_q2_again 00402008 1 00403008 03e00008 0 00000000
b4_ret_q3 00000000 1 00404008 03e00008 0 00000000
b4_push 00402008 1 00405000 0c000100 0 00000000
b4_q2_kept 00403008 0 00000000 00000000 1 00405008
b5_jr_other 00404008 1 00402008 01000008 1 00405008
b5_addiu 00404008 1 00402008 24080001 1 00405008
b5_q1_evicted 00402008 0 00000000 00000000 0 00000000

// File: filelist.f
hdl/ret_pkg.sv
hdl/lutram_dual_port.sv
hdl/rpct.sv
hdl/branch_decode.sv
hdl/return_stack.sv
hdl/ret_predictor_top.sv
bench/ret_predictor_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module ret_predictor_tb \
    -f filelist.f \
    -o ret_predictor_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/ret_predictor_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

// File: bench/ret_predictor_tb.sv
`timescale 1ns/1ps

module ret_predictor_tb
    import ret_pkg::*;
();

    localparam string GOLDEN_PATH   = "bench/ret_golden.txt";
    localparam int    READY_TIMEOUT = 64;
    localparam int    SWEEP_CYCLES  = 8;

    logic   clk = 1'b0;
    logic   rst_n;
    addr_t  fetch_pc;
    logic   exe_valid;
    addr_t  exe_pc;
    instr_t exe_instr;
    logic   predict_valid;
    addr_t  predict_target;
    logic   ready;

    // one raw text line and its parsed columns
    logic [8*128-1:0] line;
    logic [8*32-1:0]  name;
    logic [31:0]      col_fetch_pc;
    logic [31:0]      col_exe_valid;
    logic [31:0]      col_exe_pc;
    logic [31:0]      col_exe_instr;
    logic [31:0]      col_exp_valid;
    logic [31:0]      col_exp_target;

    ret_predictor_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_pc      (fetch_pc),
        .exe_valid     (exe_valid),
        .exe_pc        (exe_pc),
        .exe_instr     (exe_instr),
        .predict_valid (predict_valid),
        .predict_target(predict_target),
        .ready         (ready)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input logic [8*32-1:0] test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("FAIL %0s %0s expected %h actual %h", test, what, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "output mismatch");
        end
    endtask

    // drive on the falling edge and check before the next rising edge
    task automatic apply_vector();
        @(negedge clk);
        fetch_pc  = col_fetch_pc;
        exe_valid = col_exe_valid[0];
        // idle slots get a random pc that cannot change any result
        exe_pc    = col_exe_valid[0] ? col_exe_pc : $urandom();
        exe_instr = col_exe_instr;
        #2;
        check_value(name, "ready", 32'd1, {31'b0, ready});
        check_value(name, "predict_valid", col_exp_valid, {31'b0, predict_valid});
        check_value(name, "predict_target", col_exp_target, predict_target);
    endtask

    initial begin
        int fd;
        int fields;
        int vectors;
        int wait_cycles;

        void'($urandom(32'hb10b));
        rst_n     = 1'b0;
        fetch_pc  = '0;
        exe_valid = 1'b0;
        exe_pc    = '0;
        exe_instr = '0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("after_reset", "ready", 32'd0, {31'b0, ready});
        check_value("after_reset", "predict_valid", 32'd0, {31'b0, predict_valid});

        // table sweep runs for SET_NUM cycles
        wait_cycles = 0;
        while (!ready && wait_cycles < READY_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!ready) begin
            abort_run("ready never rose after reset");
        end
        check_value("ready_rise", "sweep_cycles", SWEEP_CYCLES, wait_cycles);

        fd = $fopen(GOLDEN_PATH, "r");
        if (fd == 0) begin
            abort_run("cannot open the golden file bench/ret_golden.txt");
        end

        vectors = 0;
        while (!$feof(fd)) begin
            line = '0;
            name = '0;
            if ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%s %h %h %h %h %h %h", name, col_fetch_pc,
                                 col_exe_valid, col_exe_pc, col_exe_instr,
                                 col_exp_valid, col_exp_target);
                // blank lines and lines opened by a lone # are skipped
                if (fields > 0 && !(name[255:8] == '0 && name[7:0] == "#")) begin
                    if (fields != 7) begin
                        abort_run("malformed line in the golden file");
                    end
                    apply_vector();
                    vectors++;
                end
            end
        end
        $fclose(fd);

        if (vectors == 0) begin
            abort_run("the golden file holds no vectors");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: hdl/ret_predictor_top.sv
`timescale 1ns/1ps

module ret_predictor_top
    import ret_pkg::*;
#(
    parameter int ASSOCIATIVITY = 2,
    parameter int SET_NUM       = 8,
    parameter int RAS_DEPTH     = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    input  addr_t  fetch_pc,
    input  logic   exe_valid,
    input  addr_t  exe_pc,
    input  instr_t exe_instr,
    output logic   predict_valid,
    output addr_t  predict_target,
    output logic   ready
);

    op_class_t op_class;
    addr_t     link_addr;
    logic      is_write;
    logic      hit;

    branch_decode decode_i (
        .exe_valid(exe_valid),
        .exe_pc   (exe_pc),
        .exe_instr(exe_instr),
        .op_class (op_class),
        .link_addr(link_addr),
        .is_write (is_write)
    );

    // table holds pcs of executed jr ra
    rpct #(
        .ASSOCIATIVITY(ASSOCIATIVITY),
        .SET_NUM      (SET_NUM)
    ) rpct_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .is_write(is_write),
        .pc_check(fetch_pc),
        .jrra_pc (exe_pc),
        .hit     (hit),
        .ready   (ready)
    );

    return_stack #(
        .RAS_DEPTH(RAS_DEPTH)
    ) ras_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .op_class      (op_class),
        .link_addr     (link_addr),
        .hit           (hit),
        .predict_valid (predict_valid),
        .predict_target(predict_target)
    );

endmodule

// File: hdl/return_stack.sv
`timescale 1ns/1ps

module return_stack
    import ret_pkg::*;
#(
    parameter int RAS_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  op_class_t op_class,
    input  addr_t     link_addr,
    input  logic      hit,
    output logic      predict_valid,
    output addr_t     predict_target
);

    localparam int PTR_BITS = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(RAS_DEPTH + 1);

    addr_t               entries [RAS_DEPTH];
    logic [PTR_BITS-1:0] top;
    logic [PTR_BITS-1:0] top_up;
    logic [PTR_BITS-1:0] top_down;
    logic [CNT_BITS-1:0] count;
    logic                empty;
    logic                full;

    // circular pointer arithmetic
    assign top_up   = (top == PTR_BITS'(RAS_DEPTH - 1)) ? '0 : top + 1'b1;
    assign top_down = (top == '0) ? PTR_BITS'(RAS_DEPTH - 1) : top - 1'b1;

    assign empty = (count == '0);
    assign full  = (count == CNT_BITS'(RAS_DEPTH));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top   <= '0;
            count <= '0;
        end else if (op_class == OP_CALL) begin
            top <= top_up;
            // when full the oldest slot is reused, count saturates
            if (!full) begin
                count <= count + 1'b1;
            end
        end else if (op_class == OP_RETURN && !empty) begin
            top   <= top_down;
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (op_class == OP_CALL) begin
            entries[top_up] <= link_addr;
        end
    end

    // top entry before any pop in this cycle
    assign predict_valid  = hit && !empty;
    assign predict_target = predict_valid ? entries[top] : '0;

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n) count <= CNT_BITS'(RAS_DEPTH)
    );

endmodule

// File: hdl/branch_decode.sv
`timescale 1ns/1ps

module branch_decode
    import ret_pkg::*;
(
    input  logic      exe_valid,
    input  addr_t     exe_pc,
    input  instr_t    exe_instr,
    output op_class_t op_class,
    output addr_t     link_addr,
    output logic      is_write
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rs;

    assign opcode = exe_instr[31:26];
    assign rs     = exe_instr[25:21];
    assign funct  = exe_instr[5:0];

    always_comb begin
        op_class = OP_OTHER;
        if (exe_valid) begin
            case (opcode)
                OPC_JAL: begin
                    op_class = OP_CALL;
                end
                OPC_SPECIAL: begin
                    if (funct == FN_JALR) begin
                        op_class = OP_CALL;
                    end else if (funct == FN_JR && rs == REG_RA) begin
                        // only jr ra counts as a return
                        op_class = OP_RETURN;
                    end
                end
                default: begin
                    op_class = OP_OTHER;
                end
            endcase
        end
    end

    // return lands after the delay slot
    assign link_addr = exe_pc + 32'd8;

    // a valid return records its pc in the table
    assign is_write = (op_class == OP_RETURN);

endmodule

// File: hdl/rpct.sv
`timescale 1ns/1ps

module rpct
    import ret_pkg::*;
#(
    parameter int ASSOCIATIVITY = 2,
    parameter int SET_NUM       = 8
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  is_write,
    input  addr_t pc_check,
    input  addr_t jrra_pc,
    output logic  hit,
    output logic  ready
);

    localparam int INDEX_BITS = $clog2(SET_NUM);
    localparam int WAY_BITS   = (ASSOCIATIVITY > 1) ? $clog2(ASSOCIATIVITY) : 1;
    localparam int TAG_BITS   = 30 - INDEX_BITS;

    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [WAY_BITS-1:0]   way_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } meta_t;

    typedef meta_t [ASSOCIATIVITY-1:0] row_t;

    typedef enum logic {
        INIT_CLEAR,
        INIT_RUN
    } init_state_t;

    init_state_t        state;
    index_t             sweep_idx;
    logic               clearing;
    logic               do_write;
    index_t             fetch_idx;
    index_t             write_idx;
    tag_t               fetch_tag;
    tag_t               write_tag;
    row_t               fetch_row;
    row_t               write_row;
    row_t               merged_row;
    row_t               ram_wdata;
    way_t               hit_way;
    way_t               write_way;
    way_t               same_way;
    way_t               inv_way;
    logic               same_found;
    logic               inv_found;
    logic [SET_NUM-1:0] plru_q;
    logic               dup_tag;

    assign fetch_idx = pc_check[2+INDEX_BITS-1:2];
    assign fetch_tag = pc_check[31:2+INDEX_BITS];
    assign write_idx = jrra_pc[2+INDEX_BITS-1:2];
    assign write_tag = jrra_pc[31:2+INDEX_BITS];

    assign clearing = (state == INIT_CLEAR);
    assign ready    = (state == INIT_RUN);
    assign do_write = is_write && ready;

    // sweep zero rows, then stay in run
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= INIT_CLEAR;
            sweep_idx <= '0;
        end else if (state == INIT_CLEAR) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == index_t'(SET_NUM - 1)) begin
                state <= INIT_RUN;
            end
        end
    end

    // tag compare on the fetch set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < ASSOCIATIVITY; i++) begin
            if (ready && fetch_row[i].valid && fetch_row[i].tag == fetch_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(i);
            end
        end
    end

    // same tag first, then first invalid way, then plru victim
    always_comb begin
        same_found = 1'b0;
        same_way   = '0;
        inv_found  = 1'b0;
        inv_way    = '0;
        for (int i = 0; i < ASSOCIATIVITY; i++) begin
            if (!same_found && write_row[i].valid && write_row[i].tag == write_tag) begin
                same_found = 1'b1;
                same_way   = way_t'(i);
            end
            if (!inv_found && !write_row[i].valid) begin
                inv_found = 1'b1;
                inv_way   = way_t'(i);
            end
        end
        if (same_found) begin
            write_way = same_way;
        end else if (inv_found) begin
            write_way = inv_way;
        end else begin
            write_way = way_t'(plru_q[write_idx]);
        end
    end

    always_comb begin
        merged_row = write_row;
        merged_row[write_way].valid = 1'b1;
        merged_row[write_way].tag   = write_tag;
    end

    assign ram_wdata = clearing ? row_t'('0) : merged_row;

    // one plru bit per set, which covers two ways
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            plru_q <= '0;
        end else begin
            if (hit) begin
                plru_q[fetch_idx] <= ~hit_way[0];
            end
            // write goes last so it wins on a shared set
            if (do_write) begin
                plru_q[write_idx] <= ~write_way[0];
            end
        end
    end

    lutram_dual_port #(
        .ADDR_WIDTH(INDEX_BITS),
        .DATA_WIDTH($bits(row_t))
    ) meta_ram (
        .clk    (clk),
        .en_1   (clearing | do_write),
        .addr_1 (clearing ? sweep_idx : write_idx),
        .wdata  (ram_wdata),
        .rdata_1(write_row),
        .addr_2 (fetch_idx),
        .rdata_2(fetch_row)
    );

    // both read ports, so the write set is covered too
    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < ASSOCIATIVITY; i++) begin
            for (int j = i + 1; j < ASSOCIATIVITY; j++) begin
                if (fetch_row[i].valid && fetch_row[j].valid &&
                    fetch_row[i].tag == fetch_row[j].tag) begin
                    dup_tag = 1'b1;
                end
                if (write_row[i].valid && write_row[j].valid &&
                    write_row[i].tag == write_row[j].tag) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    // a hit before the sweep would read stale rows
    a_no_hit_before_ready: assert property (
        @(posedge clk) disable iff (!rst_n) !ready |-> !hit
    );

    // same-tag reuse keeps each return pc in one way
    a_no_dup_tag: assert property (
        @(posedge clk) disable iff (!rst_n) ready |-> !dup_tag
    );

endmodule

// File: hdl/lutram_dual_port.sv
`timescale 1ns/1ps

module lutram_dual_port #(
    parameter int ADDR_WIDTH = 3,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    // port 1 writes and reads
    input  logic                  en_1,
    input  logic [ADDR_WIDTH-1:0] addr_1,
    input  logic [DATA_WIDTH-1:0] wdata,
    output logic [DATA_WIDTH-1:0] rdata_1,
    // port 2 only reads
    input  logic [ADDR_WIDTH-1:0] addr_2,
    output logic [DATA_WIDTH-1:0] rdata_2
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // synchronous write
    always_ff @(posedge clk) begin
        if (en_1) begin
            mem[addr_1] <= wdata;
        end
    end

    // zero latency reads, old data during a write cycle
    assign rdata_1 = mem[addr_1];
    assign rdata_2 = mem[addr_2];

endmodule

// File: hdl/ret_pkg.sv
package ret_pkg;

    // byte address as seen by fetch and execute
    typedef logic [31:0] addr_t;

    // raw instruction word from the execute stage
    typedef logic [31:0] instr_t;

    // what the predictor needs to know about a resolved instruction
    typedef enum logic [1:0] {
        OP_OTHER  = 2'd0,
        OP_CALL   = 2'd1,
        OP_RETURN = 2'd2
    } op_class_t;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OPC_SPECIAL = 6'h00,
        OPC_JAL     = 6'h03
    } opcode_t;

    // function field of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_JALR = 6'h09
    } funct_t;

    // link register
    localparam logic [4:0] REG_RA = 5'd31;

endpackage
